// File: include/vr_params.svh
/* vector load engine widths */

`ifndef VR_PARAMS_SVH
`define VR_PARAMS_SVH

// ------------------------------------------------------------
// address and read channel
// ------------------------------------------------------------
`define VR_ADDR_W          18   // byte address
`define VR_BEAT_W          64   // one R beat
`define VR_LEN_W           8    // axi len field
`define VR_BEAT_BYTES_LOG2 3    // 8 bytes per beat

// ------------------------------------------------------------
// load side
// ------------------------------------------------------------
`define VR_BEATS_PER_LINE  4    // beats packed per line
`define VR_LINE_W          256  // load line width
`define VR_NBYTES_W        14   // byte count, up to 2048

`endif

// File: hdl/vr_axi_pkg.sv
/* read channel types */

package vr_axi_pkg;

  `include "vr_params.svh"

  // ------------------------------------------------------------
  // AR channel fields
  // ------------------------------------------------------------
  typedef logic [`VR_ADDR_W-1:0] axi_addr_t;  // byte address
  typedef logic [`VR_LEN_W-1:0]  axi_len_t;   // beats minus one

  // ------------------------------------------------------------
  // R channel fields
  // ------------------------------------------------------------
  typedef logic [`VR_BEAT_W-1:0] axi_beat_t;  // one data beat

  // standard axi response encoding
  typedef enum logic [1:0] {
    OKAY   = 2'd0,
    EXOKAY = 2'd1,
    SLVERR = 2'd2,  // slave side error
    DECERR = 2'd3   // no slave at address
  } axi_resp_e;

endpackage

// File: hdl/vr_load_pkg.sv
/* load side types */

package vr_load_pkg;

  `include "vr_params.svh"

  // ------------------------------------------------------------
  // command and line types
  // ------------------------------------------------------------
  typedef logic [`VR_NBYTES_W-1:0] num_bytes_t;  // multiple of 32
  typedef logic [`VR_LINE_W-1:0]   load_line_t;  // four beats

  // position of a beat inside its line
  typedef logic [$clog2(`VR_BEATS_PER_LINE)-1:0] beat_idx_t;

  // command issue fsm
  typedef enum logic {
    CMD_IDLE,   // ready for a command
    CMD_ISSUE   // AR request waiting on arready
  } cmd_state_e;

endpackage

// File: hdl/vr_cmd_issue.sv
/* load command intake and AR issue */

`timescale 1ns/1ps
`include "vr_params.svh"

module vr_cmd_issue
  import vr_axi_pkg::*;
  import vr_load_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       ctrl_valid,
  output logic       ctrl_ready,
  input  axi_addr_t  ctrl_addr,
  input  num_bytes_t ctrl_num_bytes,
  output logic       arvalid,
  input  logic       arready,
  output axi_addr_t  araddr,
  output axi_len_t   arlen
);

  cmd_state_e state;
  num_bytes_t beat_cnt;   // beats in the burst
  axi_len_t   len_next;
  logic       ctrl_fire;
  logic       ar_fire;

  // ------------------------------------------------------------
  // burst length
  // ------------------------------------------------------------
  assign beat_cnt = ctrl_num_bytes >> `VR_BEAT_BYTES_LOG2;
  assign len_next = axi_len_t'(beat_cnt - 1'b1);  // 2048 bytes -> 255

  assign ctrl_ready = (state == CMD_IDLE);   // one request at a time
  assign arvalid    = (state == CMD_ISSUE);
  assign ctrl_fire  = ctrl_valid && ctrl_ready;
  assign ar_fire    = arvalid && arready;

  // fsm
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= CMD_IDLE;
    end else if (ctrl_fire) begin
      state <= CMD_ISSUE;
    end else if (ar_fire) begin
      state <= CMD_IDLE;   // back to intake
    end
  end

  // request payload, held until arready
  always_ff @(posedge clk) begin
    if (ctrl_fire) begin
      araddr <= ctrl_addr;
      arlen  <= len_next;
    end
  end

endmodule

// File: hdl/vr_beat_packer.sv
/* R beat to load line packer */

`timescale 1ns/1ps
`include "vr_params.svh"

module vr_beat_packer
  import vr_axi_pkg::*;
  import vr_load_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       beat_fire,   // accepted R beat
  input  axi_beat_t  rdata,
  input  logic       rlast,
  output logic       line_done,
  output load_line_t line_data
);

  localparam int        HELD_BEATS = `VR_BEATS_PER_LINE - 1;
  localparam beat_idx_t LAST_IDX   = beat_idx_t'(HELD_BEATS);

  beat_idx_t beat_idx;               // slot of the next beat
  axi_beat_t held_beats [HELD_BEATS];  // first three beats of a line

  // ------------------------------------------------------------
  // beat position counter
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      beat_idx <= '0;
    end else if (beat_fire) begin
      if (rlast || (beat_idx == LAST_IDX)) begin
        beat_idx <= '0;   // rlast lands on a line boundary anyway
      end else begin
        beat_idx <= beat_idx + 1'b1;
      end
    end
  end

  // hold beats until the line completes
  always_ff @(posedge clk) begin
    if (beat_fire && (beat_idx != LAST_IDX)) begin
      held_beats[beat_idx] <= rdata;
    end
  end

  // ------------------------------------------------------------
  // line assembly, beat 0 in the low bits
  // ------------------------------------------------------------
  always_comb begin
    for (int i = 0; i < HELD_BEATS; i++) begin
      line_data[i*`VR_BEAT_W +: `VR_BEAT_W] = held_beats[i];
    end
    line_data[HELD_BEATS*`VR_BEAT_W +: `VR_BEAT_W] = rdata;  // fourth beat passes through
  end

  assign line_done = beat_fire && (beat_idx == LAST_IDX);

endmodule

// File: hdl/vr_resp_tracker.sv
/* per burst first error capture */

`timescale 1ns/1ps

module vr_resp_tracker
  import vr_axi_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      beat_fire,   // accepted R beat
  input  axi_resp_e rresp,
  input  logic      rlast,
  output logic      burst_done,
  output axi_resp_e burst_resp
);

  logic      err_seen;   // error already recorded this burst
  axi_resp_e err_code;   // first error code
  logic      cur_err;

  assign cur_err    = (rresp == SLVERR) || (rresp == DECERR);
  assign burst_done = beat_fire && rlast;

  // ------------------------------------------------------------
  // error flag, cleared at end of burst
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      err_seen <= 1'b0;
    end else if (beat_fire) begin
      if (rlast) begin
        err_seen <= 1'b0;
      end else if (cur_err) begin
        err_seen <= 1'b1;
      end
    end
  end

  // keep only the first one
  always_ff @(posedge clk) begin
    if (beat_fire && !err_seen && cur_err) begin
      err_code <= rresp;
    end
  end

  // burst response, valid with burst_done
  always_comb begin
    if (err_seen) begin
      burst_resp = err_code;
    end else if (cur_err) begin
      burst_resp = rresp;   // error on the last beat itself
    end else begin
      burst_resp = OKAY;    // exokay folds to okay too
    end
  end

endmodule

// File: hdl/vr_load_retire.sv
/* line and response retire */

`timescale 1ns/1ps

module vr_load_retire
  import vr_axi_pkg::*;
  import vr_load_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       line_done,
  input  load_line_t line_data,
  input  logic       burst_done,
  input  axi_resp_e  burst_resp,
  output logic       rready,
  output logic       data_valid,
  input  logic       data_ready,
  output load_line_t data_line,
  output logic       resp_valid,
  input  logic       resp_ready,
  output axi_resp_e  resp_code
);

  logic line_full;    // line register occupied
  logic resp_full;    // response register occupied
  logic line_drain;
  logic resp_drain;

  // ------------------------------------------------------------
  // handshakes and back-pressure
  // ------------------------------------------------------------
  assign line_drain = line_full && data_ready;
  assign resp_drain = resp_valid && resp_ready;

  // room for a line, and no response parked
  assign rready = (!line_full || data_ready) && !resp_full;

  assign data_valid = line_full;

  // last line of the burst is captured with the response and no
  // further line enters while resp_full, so an empty line register
  // means that burst's lines are all gone
  assign resp_valid = resp_full && !line_full;

  // ------------------------------------------------------------
  // line register
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      line_full <= 1'b0;
    end else if (line_done) begin
      line_full <= 1'b1;   // refill on same edge as drain
    end else if (line_drain) begin
      line_full <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (line_done) begin
      data_line <= line_data;
    end
  end

  // ------------------------------------------------------------
  // response register
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      resp_full <= 1'b0;
    end else if (burst_done) begin
      resp_full <= 1'b1;
    end else if (resp_drain) begin
      resp_full <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (burst_done) begin
      resp_code <= burst_resp;
    end
  end

endmodule

// File: hdl/vreader_top.sv
/* vector load engine top */

`timescale 1ns/1ps

module vreader_top
  import vr_axi_pkg::*;
  import vr_load_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  // load command
  input  logic       ctrl_valid,
  output logic       ctrl_ready,
  input  axi_addr_t  ctrl_addr,
  input  num_bytes_t ctrl_num_bytes,
  // AR channel
  output logic       arvalid,
  input  logic       arready,
  output axi_addr_t  araddr,
  output axi_len_t   arlen,
  // R channel
  input  logic       rvalid,
  output logic       rready,
  input  axi_beat_t  rdata,
  input  axi_resp_e  rresp,
  input  logic       rlast,
  // load lines
  output logic       data_valid,
  input  logic       data_ready,
  output load_line_t data_line,
  // burst response
  output logic       resp_valid,
  input  logic       resp_ready,
  output axi_resp_e  resp_code
);

  logic       beat_fire;    // one accepted R beat
  logic       line_done;
  load_line_t line_data;
  logic       burst_done;
  axi_resp_e  burst_resp;

  assign beat_fire = rvalid && rready;

  vr_cmd_issue u_cmd_issue (
    .clk            (clk),
    .rst_n          (rst_n),
    .ctrl_valid     (ctrl_valid),
    .ctrl_ready     (ctrl_ready),
    .ctrl_addr      (ctrl_addr),
    .ctrl_num_bytes (ctrl_num_bytes),
    .arvalid        (arvalid),
    .arready        (arready),
    .araddr         (araddr),
    .arlen          (arlen)
  );

  // packer and tracker see the same beat
  vr_beat_packer u_beat_packer (
    .clk       (clk),
    .rst_n     (rst_n),
    .beat_fire (beat_fire),
    .rdata     (rdata),
    .rlast     (rlast),
    .line_done (line_done),
    .line_data (line_data)
  );

  vr_resp_tracker u_resp_tracker (
    .clk        (clk),
    .rst_n      (rst_n),
    .beat_fire  (beat_fire),
    .rresp      (rresp),
    .rlast      (rlast),
    .burst_done (burst_done),
    .burst_resp (burst_resp)
  );

  vr_load_retire u_load_retire (
    .clk        (clk),
    .rst_n      (rst_n),
    .line_done  (line_done),
    .line_data  (line_data),
    .burst_done (burst_done),
    .burst_resp (burst_resp),
    .rready     (rready),
    .data_valid (data_valid),
    .data_ready (data_ready),
    .data_line  (data_line),
    .resp_valid (resp_valid),
    .resp_ready (resp_ready),
    .resp_code  (resp_code)
  );

endmodule

// File: testbench/tb_vreader.sv
/* vector load engine testbench */

`timescale 1ns/1ps
`include "vr_params.svh"

module tb_vreader
  import vr_axi_pkg::*;
  import vr_load_pkg::*;
();

  localparam int NUM_ROWS = 7;
  localparam int TIMEOUT  = 1000;   // cycles per wait
  localparam int NO_ERR   = -1;

  logic       clk;
  logic       rst_n;
  logic       ctrl_valid;
  logic       ctrl_ready;
  axi_addr_t  ctrl_addr;
  num_bytes_t ctrl_num_bytes;
  logic       arvalid;
  logic       arready;
  axi_addr_t  araddr;
  axi_len_t   arlen;
  logic       rvalid;
  logic       rready;
  axi_beat_t  rdata;
  axi_resp_e  rresp;
  logic       rlast;
  logic       data_valid;
  logic       data_ready;
  load_line_t data_line;
  logic       resp_valid;
  logic       resp_ready;
  axi_resp_e  resp_code;

  // stimulus table with one row per command
  axi_addr_t  tbl_addr     [NUM_ROWS];
  num_bytes_t tbl_bytes    [NUM_ROWS];
  int         tbl_err_beat [NUM_ROWS];   // NO_ERR for a clean burst
  axi_resp_e  tbl_err_code [NUM_ROWS];
  logic       tbl_stall    [NUM_ROWS];   // random data/resp ready stalls

  axi_addr_t   ar_addr_q [$];   // AR requests seen by the slave model
  axi_len_t    ar_len_q  [$];
  logic [31:0] lcg_state = 32'd41615;

  vreader_top DUT (
    .clk            (clk),
    .rst_n          (rst_n),
    .ctrl_valid     (ctrl_valid),
    .ctrl_ready     (ctrl_ready),
    .ctrl_addr      (ctrl_addr),
    .ctrl_num_bytes (ctrl_num_bytes),
    .arvalid        (arvalid),
    .arready        (arready),
    .araddr         (araddr),
    .arlen          (arlen),
    .rvalid         (rvalid),
    .rready         (rready),
    .rdata          (rdata),
    .rresp          (rresp),
    .rlast          (rlast),
    .data_valid     (data_valid),
    .data_ready     (data_ready),
    .data_line      (data_line),
    .resp_valid     (resp_valid),
    .resp_ready     (resp_ready),
    .resp_code      (resp_code)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;   // 100 ns period
  end

  // ------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------
  function automatic int next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return int'(lcg_state[30:16]);   // upper state bits
  endfunction

  // slave data pattern with address high and inverse low
  function automatic axi_beat_t beat_value(axi_addr_t addr);
    logic [31:0] a32;
    a32 = 32'(addr);
    return {a32, ~a32};
  endfunction

  function automatic load_line_t expected_line(axi_addr_t line_addr);
    load_line_t exp_line;
    for (int j = 0; j < `VR_BEATS_PER_LINE; j++) begin
      exp_line[j*`VR_BEAT_W +: `VR_BEAT_W] = beat_value(line_addr + axi_addr_t'(j * 8));
    end
    return exp_line;
  endfunction

  function automatic axi_resp_e expected_resp(int row);
    axi_resp_e code;
    if (tbl_err_beat[row] == NO_ERR) begin
      code = OKAY;
    end else begin
      code = tbl_err_code[row];
    end
    return code;
  endfunction

  // error on the chosen beat plus a different error on a later last beat
  function automatic axi_resp_e beat_resp(int row, int beat, int nbeats);
    axi_resp_e code;
    if (beat == tbl_err_beat[row]) begin
      code = tbl_err_code[row];
    end else if (tbl_err_beat[row] != NO_ERR && beat == nbeats - 1 &&
                 beat > tbl_err_beat[row]) begin
      code = (tbl_err_code[row] == SLVERR) ? DECERR : SLVERR;   // must be ignored
    end else begin
      code = OKAY;
    end
    return code;
  endfunction

  task automatic set_row(int r, axi_addr_t addr, num_bytes_t nbytes, int err_beat,
                         axi_resp_e err_code, logic stall);
    tbl_addr[r]     = addr;
    tbl_bytes[r]    = nbytes;
    tbl_err_beat[r] = err_beat;
    tbl_err_code[r] = err_code;
    tbl_stall[r]    = stall;
  endtask

  task automatic load_table();
    set_row(0, 18'h00000, 14'd32,   NO_ERR, OKAY,   1'b0);   // single line
    set_row(1, 18'h00100, 14'd128,  5,      SLVERR, 1'b0);
    set_row(2, 18'h01000, 14'd2048, NO_ERR, OKAY,   1'b1);   // longest burst
    set_row(3, 18'h00040, 14'd64,   7,      DECERR, 1'b1);   // error on last beat
    set_row(4, 18'h3f000, 14'd256,  0,      SLVERR, 1'b1);
    set_row(5, 18'h20020, 14'd96,   11,     DECERR, 1'b0);
    set_row(6, 18'h00e00, 14'd512,  30,     DECERR, 1'b1);
  endtask

  // ------------------------------------------------------------
  // failure reporting and compare tasks
  // ------------------------------------------------------------
  task automatic stop_with_fail();
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  task automatic abort_run(string what);
    $display("ERROR: %s at %0t", what, $time);
    stop_with_fail();
  endtask

  task automatic check_addr(string name, axi_addr_t exp, axi_addr_t act);
    if (act !== exp) begin
      $display("MISMATCH %s expected %h actual %h", name, exp, act);
      stop_with_fail();
    end
  endtask

  task automatic check_len(string name, axi_len_t exp, axi_len_t act);
    if (act !== exp) begin
      $display("MISMATCH %s expected %0d actual %0d", name, exp, act);
      stop_with_fail();
    end
  endtask

  task automatic check_flag(string name, logic exp, logic act);
    if (act !== exp) begin
      $display("MISMATCH %s expected %b actual %b", name, exp, act);
      stop_with_fail();
    end
  endtask

  task automatic check_line(string name, load_line_t exp, load_line_t act);
    if (act !== exp) begin
      $display("MISMATCH %s expected %h actual %h", name, exp, act);
      stop_with_fail();
    end
  endtask

  task automatic check_resp(string name, axi_resp_e exp, axi_resp_e act);
    if (act !== exp) begin
      $display("MISMATCH %s expected %s actual %s", name, exp.name(), act.name());
      stop_with_fail();
    end
  endtask

  // ------------------------------------------------------------
  // stimulus processes entered at posedge + 1 ns
  // ------------------------------------------------------------
  task automatic drive_commands();
    int waited;
    for (int r = 0; r < NUM_ROWS; r++) begin
      ctrl_valid     = 1'b1;   // back to back with no gaps
      ctrl_addr      = tbl_addr[r];
      ctrl_num_bytes = tbl_bytes[r];
      waited         = 0;
      @(negedge clk);
      while (!ctrl_ready) begin
        waited++;
        if (waited > TIMEOUT) abort_run("load command was never accepted");
        @(negedge clk);
      end
      @(posedge clk);
      #1;
    end
    ctrl_valid = 1'b0;
  endtask

  // slave AR side checks each request against its row
  task automatic accept_ar();
    int       waited;
    axi_len_t exp_len;
    for (int r = 0; r < NUM_ROWS; r++) begin
      exp_len = axi_len_t'((int'(tbl_bytes[r]) / 8) - 1);
      waited  = 0;
      arready = (next_rand() % 3 != 0);
      @(negedge clk);
      while (!(arvalid && arready)) begin
        waited++;
        if (waited > TIMEOUT) abort_run("AR request did not arrive");
        @(posedge clk);
        #1;
        arready = (next_rand() % 3 != 0);
        @(negedge clk);
      end
      check_addr($sformatf("row %0d araddr", r), tbl_addr[r], araddr);
      check_len($sformatf("row %0d arlen", r), exp_len, arlen);
      ar_addr_q.push_back(araddr);
      ar_len_q.push_back(arlen);
      @(posedge clk);
      #1;
    end
    arready = 1'b0;
  endtask

  // slave R side with one burst per queued request
  task automatic drive_r();
    int        waited;
    int        nbeats;
    axi_addr_t base;
    for (int r = 0; r < NUM_ROWS; r++) begin
      waited = 0;
      while (ar_addr_q.size() == 0) begin
        waited++;
        if (waited > TIMEOUT) abort_run("no AR request queued for the next burst");
        @(posedge clk);
        #1;
      end
      base   = ar_addr_q.pop_front();
      nbeats = int'(ar_len_q.pop_front()) + 1;
      for (int k = 0; k < nbeats; k++) begin
        rvalid = 1'b0;
        repeat (next_rand() % 3) begin   // idle gap before raising rvalid
          @(posedge clk);
          #1;
        end
        rvalid = 1'b1;
        rdata  = beat_value(base + axi_addr_t'(k * 8));
        rresp  = beat_resp(r, k, nbeats);
        rlast  = (k == nbeats - 1);
        waited = 0;
        @(negedge clk);
        while (!rready) begin   // beat held until accepted
          waited++;
          if (waited > TIMEOUT) abort_run("R beat was never accepted");
          @(negedge clk);
        end
        @(posedge clk);
        #1;
      end
      rvalid = 1'b0;
      rlast  = 1'b0;
    end
  endtask

  // ------------------------------------------------------------
  // output side takes the lines then the response of each burst
  // ------------------------------------------------------------
  task automatic collect_outputs();
    int    waited;
    int    nlines;
    string name;
    for (int r = 0; r < NUM_ROWS; r++) begin
      nlines = int'(tbl_bytes[r]) / 32;
      for (int l = 0; l < nlines; l++) begin
        name       = $sformatf("row %0d line %0d", r, l);
        waited     = 0;
        resp_ready = 1'b0;
        data_ready = tbl_stall[r] ? (next_rand() % 2 == 0) : 1'b1;
        @(negedge clk);
        while (!(data_valid && data_ready)) begin
          if (resp_valid) abort_run("response raised before the last line of its burst");
          if (data_valid) check_flag({name, " rready"}, 1'b0, rready);   // line stalled
          waited++;
          if (waited > TIMEOUT) abort_run("load line did not arrive");
          @(posedge clk);
          #1;
          data_ready = tbl_stall[r] ? (next_rand() % 2 == 0) : 1'b1;
          @(negedge clk);
        end
        if (resp_valid) abort_run("response raised before the last line of its burst");
        check_line(name, expected_line(tbl_addr[r] + axi_addr_t'(l * 32)), data_line);
        @(posedge clk);
        #1;
      end
      data_ready = 1'b0;   // no line may come before this response
      resp_ready = tbl_stall[r] ? (next_rand() % 2 == 0) : 1'b1;
      waited     = 0;
      @(negedge clk);
      while (!(resp_valid && resp_ready)) begin
        check_flag($sformatf("row %0d rready", r), 1'b0, rready);   // response parked
        waited++;
        if (waited > TIMEOUT) abort_run("burst response did not arrive");
        @(posedge clk);
        #1;
        resp_ready = tbl_stall[r] ? (next_rand() % 2 == 0) : 1'b1;
        @(negedge clk);
      end
      check_flag($sformatf("row %0d rready", r), 1'b0, rready);
      check_resp($sformatf("row %0d resp", r), expected_resp(r), resp_code);
      @(posedge clk);
      #1;
    end
    data_ready = 1'b0;
    resp_ready = 1'b0;
  endtask

  // ------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------
  initial begin
    rst_n          = 1'b0;
    ctrl_valid     = 1'b0;
    ctrl_addr      = '0;
    ctrl_num_bytes = '0;
    arready        = 1'b0;
    rvalid         = 1'b0;
    rdata          = '0;
    rresp          = OKAY;
    rlast          = 1'b0;
    data_ready     = 1'b0;
    resp_ready     = 1'b0;
    load_table();
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    if (!ctrl_ready || arvalid || data_valid || resp_valid) begin
      abort_run("wrong handshake levels after reset");
    end
    @(posedge clk);
    #1;
    fork
      drive_commands();
      accept_ar();
      drive_r();
      collect_outputs();
    join
    // nothing extra may show up after the last burst
    data_ready = 1'b1;
    resp_ready = 1'b1;
    repeat (20) begin
      @(negedge clk);
      if (data_valid || resp_valid || arvalid) abort_run("extra output after the last burst");
    end
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

// File: project.f
+incdir+include
hdl/vr_axi_pkg.sv
hdl/vr_load_pkg.sv
hdl/vr_cmd_issue.sv
hdl/vr_beat_packer.sv
hdl/vr_resp_tracker.sv
hdl/vr_load_retire.sv
hdl/vreader_top.sv
testbench/tb_vreader.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = tb_vreader
FILELIST  = project.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = Simulation finished: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
